//--- common/phy_settings.svh
// Build-time settings for the PHY count, reset and hold timing, debounce and strap values
`ifndef PHY_SETTINGS_SVH
`define PHY_SETTINGS_SVH

// Number of PHY ports on the front end
`define PHY_COUNT 2

// Clock cycles the PHY stays in hardware reset after the reset level drops
// Short value for simulation, a real board needs milliseconds here
`define PHY_RESET_CYCLES 16

// Cycles the straps stay driven after hardware reset is released
// The PHY latches its configuration pins on the rising edge of reset
`define PHY_HOLD_CYCLES 8

// Stable samples of the synchronized key before the reset level follows it
`define DEBOUNCE_CYCLES 4

// Hardware configuration pattern put on RXD[7:0] during reset
// Selects the interface mode and autonegotiation advertisement
`define PHY_MODE_STRAP 8'h5c

// MDIO address of port 0
// Port k straps base plus k on its LED/address pins
`define PHY_ADDR_BASE 5'h10

`endif

//--- common/phy_pkg.sv
// Shared types for the PHY strap value and the seven-segment display bank
package phy_pkg;

	// Values the initializer forces onto the PHY pins while in reset
	typedef struct packed {
		// PHY address, placed on the LED/address pins
		logic [4:0] addr;
		// Mode configuration, placed on RXD[7:0]
		logic [7:0] mode;
		// Extra configuration bit on RX_DV
		logic       rx_dv;
	} phy_strap_t;

	// One digit, active low, bit 0 is segment a
	typedef logic [6:0] seg7_t;

	// All eight digits of the board, digit 0 in the lowest slot
	typedef seg7_t [7:0] hex_bank_t;

endpackage

//--- src/reset_control.sv
// Reset key synchronizer and debouncer producing the shared PHY reset level
`timescale 1ns/100ps
`include "phy_settings.svh"

module reset_control (
	input  logic clk_50,
	input  logic rst_n,
	input  logic key_n,
	output logic phy_reset
);

	// Counter must hold values up to DEBOUNCE_CYCLES - 1
	localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);

	// Two-stage synchronizer for the asynchronous button
	logic key_meta;
	logic key_sync;
	// Run length of samples that disagree with the current reset level
	logic [CNT_W-1:0] stable_cnt;
	// Button pressed, as a reset request
	logic press;

	// Key is active low
	assign press = ~key_sync;

	always_ff @(posedge clk_50) begin
		if (!rst_n) begin
			// Idle key level so no false press right after reset
			key_meta <= 1'b1;
			key_sync <= 1'b1;
		end else begin
			key_meta <= key_n;
			key_sync <= key_meta;
		end
	end

	always_ff @(posedge clk_50) begin
		if (!rst_n) begin
			// Board reset forces the PHYs into reset straight away
			stable_cnt <= '0;
			phy_reset  <= 1'b1;
		end else if (press == phy_reset) begin
			// Sample agrees, any partial run was a bounce
			stable_cnt <= '0;
		end else if (stable_cnt == CNT_W'(`DEBOUNCE_CYCLES - 1)) begin
			// Enough disagreeing samples in a row, follow the key
			phy_reset  <= press;
			stable_cnt <= '0;
		end else begin
			stable_cnt <= stable_cnt + 1'b1;
		end
	end

endmodule

//--- phy_init/phy_init.sv
// Per-PHY hardware reset and configuration strap sequencer with tristate pin drivers
`timescale 1ns/100ps
`include "phy_settings.svh"

module phy_init #(
	parameter phy_pkg::phy_strap_t STRAP = '{addr: 5'd0, mode: 8'd0, rx_dv: 1'b1}
) (
	input  logic       clk_50,
	input  logic       rst_n,
	input  logic       phy_reset,
	output logic       ready,
	inout  wire  [7:0] phy_rxd,
	inout  wire        phy_rx_dv,
	inout  wire  [4:0] phy_addr,
	output logic       phy_hw_rst,
	output logic       phy_mdc,
	inout  wire        phy_mio
);

	// One counter serves both timed phases, size it for the longer one
	localparam int MAX_CYC = (`PHY_RESET_CYCLES > `PHY_HOLD_CYCLES) ?
		`PHY_RESET_CYCLES : `PHY_HOLD_CYCLES;
	localparam int CNT_W = $clog2(MAX_CYC + 1);

	// RESET holds the PHY in reset, HOLD keeps straps after release
	typedef enum logic [1:0] {
		ST_RESET,
		ST_HOLD,
		ST_DONE
	} state_t;

	state_t state;
	logic [CNT_W-1:0] cnt;
	// Straps on the pins while the PHY can still latch them
	logic strap_en;

	always_ff @(posedge clk_50) begin
		if (!rst_n || phy_reset) begin
			// Reload so the reset phase restarts from its full length
			state <= ST_RESET;
			cnt   <= CNT_W'(`PHY_RESET_CYCLES - 1);
		end else begin
			case (state)
				ST_RESET: begin
					if (cnt == '0) begin
						// Release hardware reset, start the strap hold time
						state <= ST_HOLD;
						cnt   <= CNT_W'(`PHY_HOLD_CYCLES - 1);
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				ST_HOLD: begin
					if (cnt == '0) begin
						state <= ST_DONE;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				// Stay here until the reset level comes back
				default: begin
					state <= ST_DONE;
				end
			endcase
		end
	end

	// Outputs come straight from the state register
	assign phy_hw_rst = (state != ST_RESET);
	assign ready      = (state == ST_DONE);
	assign strap_en   = (state != ST_DONE);

	// These pins are PHY outputs in normal operation
	assign phy_rxd   = strap_en ? STRAP.mode  : 8'bz;
	assign phy_rx_dv = strap_en ? STRAP.rx_dv : 1'bz;
	assign phy_addr  = strap_en ? STRAP.addr  : 5'bz;

	// No management interface yet
	// MDC parked low, MDIO left to the PHY's pull-up
	assign phy_mdc = 1'b0;
	assign phy_mio = 1'bz;

endmodule

//--- display/seg7_decode.sv
// Hex nibble to active-low seven-segment decoder with blanking
`timescale 1ns/100ps

module seg7_decode (
	input  logic [3:0]     nibble,
	input  logic           blank,
	output phy_pkg::seg7_t seg
);

	always_comb begin
		if (blank) begin
			// All segments dark
			seg = 7'h7f;
		end else begin
			// Segment order gfedcba, low turns a segment on
			case (nibble)
				4'h0: seg = 7'b1000000;
				4'h1: seg = 7'b1111001;
				4'h2: seg = 7'b0100100;
				4'h3: seg = 7'b0110000;
				4'h4: seg = 7'b0011001;
				4'h5: seg = 7'b0010010;
				4'h6: seg = 7'b0000010;
				4'h7: seg = 7'b1111000;
				4'h8: seg = 7'b0000000;
				4'h9: seg = 7'b0010000;
				// Letters drawn as A b C d E F
				4'ha: seg = 7'b0001000;
				4'hb: seg = 7'b0000011;
				4'hc: seg = 7'b1000110;
				4'hd: seg = 7'b0100001;
				4'he: seg = 7'b0000110;
				default: seg = 7'b0001110;
			endcase
		end
	end

endmodule

//--- display/status_display.sv
// Status LEDs and seven-segment digits for PHY ready flags and switch entry
`timescale 1ns/100ps
`include "phy_settings.svh"

module status_display (
	input  logic                  clk_50,
	input  logic                  rst_n,
	input  logic [`PHY_COUNT-1:0] ready,
	input  logic [17:0]           sw,
	output phy_pkg::hex_bank_t    hex,
	output logic [8:0]            ledg,
	output logic [17:0]           ledr
);

	// Per-digit value and blank flag feeding the decoders
	logic [3:0] nib [8];
	logic [7:0] blank;
	// Number of PHYs through their sequence
	logic [3:0] ready_cnt;
	phy_pkg::hex_bank_t hex_next;

	always_comb begin
		ready_cnt = '0;
		for (int i = 0; i < `PHY_COUNT; i++) begin
			ready_cnt = ready_cnt + 4'(ready[i]);
		end
	end

	always_comb begin
		nib[0] = ready_cnt;
		nib[1] = 4'(ready);
		// Register address and read value digits, unused for now
		for (int d = 2; d < 6; d++) begin
			nib[d] = 4'h0;
		end
		// Value being entered on the switches
		nib[6] = sw[11:8];
		nib[7] = sw[15:12];
		blank  = 8'b0011_1100;
	end

	for (genvar d = 0; d < 8; d++) begin : g_digit
		seg7_decode u_seg (
			.nibble (nib[d]),
			.blank  (blank[d]),
			.seg    (hex_next[d])
		);
	end

	// Single output stage, so everything lags its inputs by one cycle
	always_ff @(posedge clk_50) begin
		if (!rst_n) begin
			// Dark display and LEDs off
			hex  <= '1;
			ledg <= '0;
			ledr <= '0;
		end else begin
			hex  <= hex_next;
			ledg <= 9'(ready);
			ledr <= sw;
		end
	end

endmodule

//--- src/gige_top.sv
// Top level of the two-port gigabit Ethernet bring-up, PHY init and status display
`timescale 1ns/100ps
`include "phy_settings.svh"

module gige_top (
	input  logic                       clk_50,
	input  logic                       rst_n,
	// key[0] is the reset button, active low
	input  logic [3:0]                 key,
	input  logic [17:0]                sw,
	output phy_pkg::hex_bank_t         hex,
	output logic [8:0]                 ledg,
	output logic [17:0]                ledr,
	// PHY pins, one slot per port
	inout  wire  [`PHY_COUNT-1:0][7:0] phy_rxd,
	inout  wire  [`PHY_COUNT-1:0]      phy_rx_dv,
	inout  wire  [`PHY_COUNT-1:0][4:0] phy_addr,
	output wire  [`PHY_COUNT-1:0]      phy_hw_rst,
	output wire  [`PHY_COUNT-1:0]      phy_mdc,
	inout  wire  [`PHY_COUNT-1:0]      phy_mio
);

	// Shared reset level for every initializer
	logic phy_reset;
	// One ready flag per port
	logic [`PHY_COUNT-1:0] ready;

	reset_control u_reset_control (
		.clk_50    (clk_50),
		.rst_n     (rst_n),
		.key_n     (key[0]),
		.phy_reset (phy_reset)
	);

	for (genvar k = 0; k < `PHY_COUNT; k++) begin : g_phy
		// Each port gets its own MDIO address, mode is common
		localparam phy_pkg::phy_strap_t STRAP = '{
			addr:  5'(`PHY_ADDR_BASE + k),
			mode:  `PHY_MODE_STRAP,
			rx_dv: 1'b1
		};

		phy_init #(
			.STRAP (STRAP)
		) u_phy_init (
			.clk_50     (clk_50),
			.rst_n      (rst_n),
			.phy_reset  (phy_reset),
			.ready      (ready[k]),
			.phy_rxd    (phy_rxd[k]),
			.phy_rx_dv  (phy_rx_dv[k]),
			.phy_addr   (phy_addr[k]),
			.phy_hw_rst (phy_hw_rst[k]),
			.phy_mdc    (phy_mdc[k]),
			.phy_mio    (phy_mio[k])
		);
	end

	status_display u_status_display (
		.clk_50 (clk_50),
		.rst_n  (rst_n),
		.ready  (ready),
		.sw     (sw),
		.hex    (hex),
		.ledg   (ledg),
		.ledr   (ledr)
	);

endmodule

//--- testbench/tb_checks.svh
// Compare tasks for strap, segment, bit and count results, plus mismatch counters
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Totals for the closing summary line
int error_count = 0;
int checks_done = 0;

// Strap value read back from the PHY pins of one port
task automatic check_strap(input string test, input phy_pkg::phy_strap_t exp,
	input phy_pkg::phy_strap_t act);
	checks_done++;
	if (act !== exp) begin
		error_count++;
		$display("Error in %s: strap expected addr %h mode %h rx_dv %b, actual addr %h mode %h rx_dv %b",
			test, exp.addr, exp.mode, exp.rx_dv, act.addr, act.mode, act.rx_dv);
	end
endtask

// One active-low digit pattern
task automatic check_seg(input string test, input phy_pkg::seg7_t exp, input phy_pkg::seg7_t act);
	checks_done++;
	if (act !== exp) begin
		error_count++;
		$display("Error in %s: segments expected %b, actual %b", test, exp, act);
	end
endtask

// Single control level, X or Z counts as wrong
task automatic check_bit(input string test, input logic exp, input logic act);
	checks_done++;
	if (act !== exp) begin
		error_count++;
		$display("Error in %s: bit expected %b, actual %b", test, exp, act);
	end
endtask

// Cycle counts, masks and whole words
task automatic check_count(input string test, input int exp, input int act);
	checks_done++;
	if (act !== exp) begin
		error_count++;
		$display("Error in %s: value expected %0d, actual %0d", test, exp, act);
	end
endtask

`endif

//--- testbench/tb_gige_top.sv
// Testbench for gige_top with clock, reset, pulled-down PHY pins, directed tests and watchdog
`timescale 1ns/100ps
`include "phy_settings.svh"

module tb_gige_top;

	localparam int CLK_PERIOD = 40;
	localparam int FULL_MASK = (1 << `PHY_COUNT) - 1;
	localparam int SW_ROUNDS = 8;
	// Key change to phy_reset, then reset and hold phases, plus slack
	localparam int SEQ_CYCLES = 2 + `DEBOUNCE_CYCLES + `PHY_RESET_CYCLES + `PHY_HOLD_CYCLES + 2;
	// Reset, sequence, key press with restart and glitch, switches, digits
	localparam int TEST_CYCLES = 4 + SEQ_CYCLES + (10 + 3 * `DEBOUNCE_CYCLES + SEQ_CYCLES)
		+ 2 * SW_ROUNDS + 2;
	localparam int WAIT_LIMIT = 2 * SEQ_CYCLES;

	logic clk_50 = 1'b0;
	logic rst_n;
	logic [3:0] key;
	logic [17:0] sw;
	phy_pkg::hex_bank_t hex;
	logic [8:0] ledg;
	logic [17:0] ledr;
	wire [`PHY_COUNT-1:0][7:0] phy_rxd;
	wire [`PHY_COUNT-1:0] phy_rx_dv;
	wire [`PHY_COUNT-1:0][4:0] phy_addr;
	wire [`PHY_COUNT-1:0] phy_hw_rst;
	wire [`PHY_COUNT-1:0] phy_mdc;
	wire [`PHY_COUNT-1:0] phy_mio;
	int tests_run = 0;

	`include "tb_checks.svh"

	// Board pull-downs, a released strap pin reads 0
	assign (pull0, pull1) phy_rxd = '0;
	assign (pull0, pull1) phy_rx_dv = '0;
	assign (pull0, pull1) phy_addr = '0;

	always #(CLK_PERIOD / 2) clk_50 = ~clk_50;

	gige_top gige_top_i (
		.clk_50     (clk_50),
		.rst_n      (rst_n),
		.key        (key),
		.sw         (sw),
		.hex        (hex),
		.ledg       (ledg),
		.ledr       (ledr),
		.phy_rxd    (phy_rxd),
		.phy_rx_dv  (phy_rx_dv),
		.phy_addr   (phy_addr),
		.phy_hw_rst (phy_hw_rst),
		.phy_mdc    (phy_mdc),
		.phy_mio    (phy_mio)
	);

	// Port k straps base address plus k and the common mode
	function automatic phy_pkg::phy_strap_t expected_strap(input int k);
		phy_pkg::phy_strap_t s;
		s.addr = 5'(`PHY_ADDR_BASE + k);
		s.mode = `PHY_MODE_STRAP;
		s.rx_dv = 1'b1;
		return s;
	endfunction

	function automatic phy_pkg::phy_strap_t read_strap(input int k);
		phy_pkg::phy_strap_t s;
		s.addr = phy_addr[k];
		s.mode = phy_rxd[k];
		s.rx_dv = phy_rx_dv[k];
		return s;
	endfunction

	// Board digit table, gfedcba, low lights a segment
	function automatic phy_pkg::seg7_t seg_pattern(input logic [3:0] n);
		case (n)
			4'h0: return 7'h40;
			4'h1: return 7'h79;
			4'h2: return 7'h24;
			4'h3: return 7'h30;
			4'h4: return 7'h19;
			4'h5: return 7'h12;
			4'h6: return 7'h02;
			4'h7: return 7'h78;
			4'h8: return 7'h00;
			4'h9: return 7'h10;
			4'ha: return 7'h08;
			4'hb: return 7'h03;
			4'hc: return 7'h46;
			4'hd: return 7'h21;
			4'he: return 7'h06;
			default: return 7'h0e;
		endcase
	endfunction

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (error_count == errs_before) begin
			$display("PASS %s", name);
		end else begin
			$display("FAIL %s with %0d mismatches", name, error_count - errs_before);
		end
	endtask

	// Entered with phy_reset high, returns once ledg shows every port ready
	task automatic measure_sequence(input string name);
		int n;
		n = 0;
		while (gige_top_i.phy_reset !== 1'b0 && n < WAIT_LIMIT) begin
			@(negedge clk_50);
			n++;
		end
		if (gige_top_i.phy_reset !== 1'b0) begin
			error_count++;
			$display("Timeout in %s: phy_reset never fell", name);
			return;
		end
		// Cycles from the reset level falling to hardware reset release
		n = 0;
		while (phy_hw_rst !== '1 && n < WAIT_LIMIT) begin
			@(negedge clk_50);
			n++;
		end
		check_count(name, `PHY_RESET_CYCLES, n);
		// Straps stay on the pins for the hold time
		n = 0;
		while (read_strap(0) !== '0 && n < WAIT_LIMIT) begin
			@(negedge clk_50);
			n++;
		end
		check_count(name, `PHY_HOLD_CYCLES, n);
		for (int k = 0; k < `PHY_COUNT; k++) begin
			check_strap(name, '0, read_strap(k));
		end
		// Display register adds one cycle
		check_count(name, 0, int'(ledg[`PHY_COUNT-1:0]));
		@(negedge clk_50);
		check_count(name, FULL_MASK, int'(ledg[`PHY_COUNT-1:0]));
	endtask

	task automatic straps_in_reset();
		string name = "reset_straps";
		int errs;
		errs = error_count;
		rst_n = 1'b0;
		repeat (2) @(negedge clk_50);
		rst_n = 1'b1;
		for (int k = 0; k < `PHY_COUNT; k++) begin
			check_bit(name, 1'b0, phy_hw_rst[k]);
			check_bit(name, 1'b0, phy_mdc[k]);
			// MDIO data has no pull here, so an undriven pin floats
			check_bit(name, 1'bz, phy_mio[k]);
			check_strap(name, expected_strap(k), read_strap(k));
		end
		check_count(name, 0, int'(ledg[`PHY_COUNT-1:0]));
		report_test(name, errs);
	endtask

	task automatic first_sequence();
		int errs;
		errs = error_count;
		measure_sequence("sequence");
		report_test("sequence", errs);
	endtask

	task automatic key_restart();
		string name = "key_restart";
		int errs;
		int n;
		int glitch;
		errs = error_count;
		key[0] = 1'b0;
		n = 0;
		while (gige_top_i.phy_reset !== 1'b1 && n < WAIT_LIMIT) begin
			@(negedge clk_50);
			n++;
		end
		check_count(name, 2 + `DEBOUNCE_CYCLES, n);
		// One cycle into phy_init, one more through the display register
		repeat (2) @(negedge clk_50);
		check_count(name, 0, int'(phy_hw_rst));
		check_count(name, 0, int'(ledg[`PHY_COUNT-1:0]));
		key[0] = 1'b1;
		measure_sequence(name);
		// Bounce too short for the debouncer
		glitch = 1 + $urandom % (`DEBOUNCE_CYCLES - 1);
		key[0] = 1'b0;
		repeat (glitch) @(negedge clk_50);
		key[0] = 1'b1;
		repeat (2 + `DEBOUNCE_CYCLES + 2) begin
			@(negedge clk_50);
			check_count(name, FULL_MASK, int'(ledg[`PHY_COUNT-1:0]));
		end
		check_count(name, FULL_MASK, int'(phy_hw_rst));
		report_test(name, errs);
	endtask

	task automatic switch_display();
		string name = "switches";
		int errs;
		logic [17:0] value;
		errs = error_count;
		repeat (SW_ROUNDS) begin
			value = 18'($urandom);
			sw = value;
			@(negedge clk_50);
			check_seg(name, seg_pattern(value[11:8]), hex[6]);
			check_seg(name, seg_pattern(value[15:12]), hex[7]);
			for (int d = 2; d < 6; d++) begin
				check_seg(name, 7'h7f, hex[d]);
			end
			check_count(name, int'(value), int'(ledr));
		end
		report_test(name, errs);
	endtask

	task automatic ready_digits();
		string name = "ready_digits";
		int errs;
		errs = error_count;
		@(negedge clk_50);
		check_seg(name, seg_pattern(4'(`PHY_COUNT)), hex[0]);
		check_seg(name, seg_pattern(4'(FULL_MASK)), hex[1]);
		// Nothing above the ready flags
		check_count(name, 0, int'(ledg >> `PHY_COUNT));
		report_test(name, errs);
	endtask

	initial begin
		void'($urandom(7));
		rst_n = 1'b0;
		key = 4'hf;
		sw = '0;
		straps_in_reset();
		first_sequence();
		key_restart();
		switch_display();
		ready_digits();
		$display("Tests run: %0d, checks: %0d, mismatches: %0d",
			tests_run, checks_done, error_count);
		if (error_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// Total expected test length with half again as margin
	initial begin
		#(TEST_CYCLES * 3 / 2 * CLK_PERIOD);
		$display("Watchdog expired: the tests did not finish in time");
		$display("Errors found");
		$finish;
	end

endmodule

//--- sim.f
+incdir+common
+incdir+testbench
common/phy_pkg.sv
src/reset_control.sv
phy_init/phy_init.sv
display/seg7_decode.sv
display/status_display.sv
src/gige_top.sv
testbench/tb_gige_top.sv
